// File: hw/csr_pkg.sv
// CSR unit shared definitions
`default_nettype none

package csr_pkg;

    localparam int csr_addr_w = 12;
    localparam int csr_data_w = 32;

    typedef logic [csr_addr_w-1:0] csr_addr_t;
    typedef logic [csr_data_w-1:0] csr_word_t;

    // machine status, only the fields the unit looks at
    typedef struct packed {
        logic [18:0] pad_hi;   // 31:13
        logic [1:0]  mpp;      // previous privilege
        logic [2:0]  pad_mid;  // 10:8
        logic        mpie;
        logic [2:0]  pad_lo;   // 6:4
        logic        mie;      // global interrupt enable
        logic [2:0]  pad_bot;
    } mstatus_t;

    typedef union packed {
        csr_word_t raw;
        mstatus_t  status;
    } csr_word_u;

    // writable registers, trap registers come first
    typedef enum int unsigned {
        idx_mstatus,
        idx_mie,
        idx_mtvec,
        idx_mcounteren,
        idx_mscratch,
        idx_mepc,
        idx_mcause,
        idx_mtval,
        idx_mip,
        idx_mcycle,
        idx_mcycleh,
        idx_minstret,
        idx_minstreth
    } csr_idx_e;

    localparam int csr_trap_num = int'(idx_mip) + 1;
    localparam int csr_num      = int'(idx_minstreth) + 1;

    typedef logic [csr_num-1:0] csr_vec_t;  // one bit per writable CSR

    // machine trap setup and handling
    localparam csr_addr_t csr_mstatus_a    = 12'h300;
    localparam csr_addr_t csr_misa_a       = 12'h301;
    localparam csr_addr_t csr_mie_a        = 12'h304;
    localparam csr_addr_t csr_mtvec_a      = 12'h305;
    localparam csr_addr_t csr_mcounteren_a = 12'h306;
    localparam csr_addr_t csr_mscratch_a   = 12'h340;
    localparam csr_addr_t csr_mepc_a       = 12'h341;
    localparam csr_addr_t csr_mcause_a     = 12'h342;
    localparam csr_addr_t csr_mtval_a      = 12'h343;
    localparam csr_addr_t csr_mip_a        = 12'h344;

    // counters
    localparam csr_addr_t csr_mcycle_a     = 12'hb00;
    localparam csr_addr_t csr_minstret_a   = 12'hb02;
    localparam csr_addr_t csr_mcycleh_a    = 12'hb80;
    localparam csr_addr_t csr_minstreth_a  = 12'hb82;
    localparam csr_addr_t csr_time_a       = 12'hc01;
    localparam csr_addr_t csr_timeh_a      = 12'hc81;

    // identity, read only
    localparam csr_addr_t csr_mvendorid_a  = 12'hf11;
    localparam csr_addr_t csr_marchid_a    = 12'hf12;
    localparam csr_addr_t csr_mimpid_a     = 12'hf13;
    localparam csr_addr_t csr_mhartid_a    = 12'hf14;

    localparam csr_word_t misa_value = 32'h4000_1100;  // mxl=1, I and M

endpackage

`default_nettype wire

// File: hw/csr_port_ctrl.sv
// CSR write port decode
`default_nettype none

module csr_port_ctrl (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     ex_we_i,
    input  wire                     clint_we_i,
    input  wire csr_pkg::csr_addr_t ex_waddr_i,
    input  wire csr_pkg::csr_addr_t clint_waddr_i,
    output csr_pkg::csr_vec_t       wr_en_o,       // any port writes this register
    output csr_pkg::csr_vec_t       wr_from_ex_o   // ex supplies the data
);

    import csr_pkg::*;

    csr_vec_t ex_hit;
    csr_vec_t clint_hit;

    // one-hot register select for a single port
    function automatic csr_vec_t decode(input logic we, input csr_addr_t addr);
        csr_vec_t hit;
        hit = '0;
        if (we) begin
            case (addr)
                csr_mstatus_a:    hit[idx_mstatus]    = 1'b1;
                csr_mie_a:        hit[idx_mie]        = 1'b1;
                csr_mtvec_a:      hit[idx_mtvec]      = 1'b1;
                csr_mcounteren_a: hit[idx_mcounteren] = 1'b1;
                csr_mscratch_a:   hit[idx_mscratch]   = 1'b1;
                csr_mepc_a:       hit[idx_mepc]       = 1'b1;
                csr_mcause_a:     hit[idx_mcause]     = 1'b1;
                csr_mtval_a:      hit[idx_mtval]      = 1'b1;
                csr_mip_a:        hit[idx_mip]        = 1'b1;
                csr_mcycle_a:     hit[idx_mcycle]     = 1'b1;
                csr_mcycleh_a:    hit[idx_mcycleh]    = 1'b1;
                csr_minstret_a:   hit[idx_minstret]   = 1'b1;
                csr_minstreth_a:  hit[idx_minstreth]  = 1'b1;
                // identity words, time and unknown addresses drop the write
                default: hit = '0;
            endcase
        end
        return hit;
    endfunction

    assign ex_hit    = decode(ex_we_i, ex_waddr_i);
    assign clint_hit = decode(clint_we_i, clint_waddr_i);

    // ex takes the register whenever both ports land on it
    assign wr_en_o      = ex_hit | clint_hit;
    assign wr_from_ex_o = ex_hit;

    // a port never reaches two registers at once
    a_port_onehot: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(ex_hit) && $onehot0(clint_hit)
    );

endmodule

`default_nettype wire

// File: hw/csr_trap_regs.sv
// Machine trap CSR storage
`default_nettype none

module csr_trap_regs (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire csr_pkg::csr_vec_t  wr_en_i,
    input  wire csr_pkg::csr_vec_t  wr_from_ex_i,
    input  wire csr_pkg::csr_word_t ex_wdata_i,
    input  wire csr_pkg::csr_word_t clint_wdata_i,
    output csr_pkg::csr_word_u      mstatus_o,
    output csr_pkg::csr_word_t      mtvec_o,
    output csr_pkg::csr_word_t      mepc_o,
    output csr_pkg::csr_word_t      mcause_o,
    output csr_pkg::csr_word_t      mie_o,
    output csr_pkg::csr_word_t      mip_o,
    output csr_pkg::csr_word_t      mtval_o,
    output csr_pkg::csr_word_t      mscratch_o,
    output csr_pkg::csr_word_t      mcounteren_o,
    output logic                    global_int_en_o
);

    import csr_pkg::*;

    // indexed by csr_idx_e, trap entries only
    csr_word_t trap_q [csr_trap_num];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < csr_trap_num; i++) begin
                trap_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < csr_trap_num; i++) begin
                if (wr_en_i[i]) begin
                    trap_q[i] <= wr_from_ex_i[i] ? ex_wdata_i : clint_wdata_i;
                end
            end
        end
    end

    assign mstatus_o    = csr_word_u'(trap_q[idx_mstatus]);
    assign mtvec_o      = trap_q[idx_mtvec];
    assign mepc_o       = trap_q[idx_mepc];
    assign mcause_o     = trap_q[idx_mcause];
    assign mie_o        = trap_q[idx_mie];
    assign mip_o        = trap_q[idx_mip];
    assign mtval_o      = trap_q[idx_mtval];
    assign mscratch_o   = trap_q[idx_mscratch];
    assign mcounteren_o = trap_q[idx_mcounteren];

    assign global_int_en_o = mstatus_o.status.mie;  // field view of the same word

    // enable follows bit 3 of whichever port won the mstatus write
    a_int_en_follows_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wr_en_i[idx_mstatus] |=> global_int_en_o ==
            $past(wr_from_ex_i[idx_mstatus] ? ex_wdata_i[3] : clint_wdata_i[3])
    );

endmodule

`default_nettype wire

// File: hw/csr_counters.sv
// Split 64-bit machine counters
`default_nettype none

module csr_counters (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     inst_valid_i,
    input  wire csr_pkg::csr_vec_t  wr_en_i,
    input  wire csr_pkg::csr_vec_t  wr_from_ex_i,
    input  wire csr_pkg::csr_word_t ex_wdata_i,
    input  wire csr_pkg::csr_word_t clint_wdata_i,
    output csr_pkg::csr_word_t      mcycle_o,
    output csr_pkg::csr_word_t      mcycleh_o,
    output csr_pkg::csr_word_t      minstret_o,
    output csr_pkg::csr_word_t      minstreth_o,
    output csr_pkg::csr_word_t      time_o,
    output csr_pkg::csr_word_t      timeh_o
);

    import csr_pkg::*;

    csr_word_t mcycle_q;
    csr_word_t mcycleh_q;
    csr_word_t minstret_q;
    csr_word_t minstreth_q;
    csr_word_t time_q;
    csr_word_t timeh_q;

    csr_word_t cyc_wd;
    csr_word_t cych_wd;
    csr_word_t ret_wd;
    csr_word_t reth_wd;

    logic [2*csr_data_w-1:0] mcycle_nxt;
    logic [2*csr_data_w-1:0] minstret_nxt;
    logic [2*csr_data_w-1:0] time_nxt;

    // next {hi, lo}; a written high half still picks up the low carry
    function automatic logic [2*csr_data_w-1:0] step(
        input csr_word_t lo,
        input csr_word_t hi,
        input logic      inc,
        input logic      we_lo,
        input logic      we_hi,
        input csr_word_t wd_lo,
        input csr_word_t wd_hi
    );
        logic      carry;
        csr_word_t lo_n;
        csr_word_t hi_n;
        carry = inc && (lo == '1);
        lo_n  = we_lo ? wd_lo : lo + csr_word_t'(inc);
        hi_n  = (we_hi ? wd_hi : hi) + csr_word_t'(carry);
        return {hi_n, lo_n};
    endfunction

    assign cyc_wd  = wr_from_ex_i[idx_mcycle]    ? ex_wdata_i : clint_wdata_i;
    assign cych_wd = wr_from_ex_i[idx_mcycleh]   ? ex_wdata_i : clint_wdata_i;
    assign ret_wd  = wr_from_ex_i[idx_minstret]  ? ex_wdata_i : clint_wdata_i;
    assign reth_wd = wr_from_ex_i[idx_minstreth] ? ex_wdata_i : clint_wdata_i;

    assign mcycle_nxt   = step(mcycle_q, mcycleh_q, 1'b1,
                               wr_en_i[idx_mcycle], wr_en_i[idx_mcycleh], cyc_wd, cych_wd);
    assign minstret_nxt = step(minstret_q, minstreth_q, inst_valid_i,
                               wr_en_i[idx_minstret], wr_en_i[idx_minstreth], ret_wd, reth_wd);
    assign time_nxt     = step(time_q, timeh_q, 1'b1, 1'b0, 1'b0, '0, '0);  // no write path

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mcycle_q    <= '0;
            mcycleh_q   <= '0;
            minstret_q  <= '0;
            minstreth_q <= '0;
            time_q      <= '0;
            timeh_q     <= '0;
        end else begin
            {mcycleh_q, mcycle_q}     <= mcycle_nxt;
            {minstreth_q, minstret_q} <= minstret_nxt;
            {timeh_q, time_q}         <= time_nxt;
        end
    end

    assign mcycle_o    = mcycle_q;
    assign mcycleh_o   = mcycleh_q;
    assign minstret_o  = minstret_q;
    assign minstreth_o = minstreth_q;
    assign time_o      = time_q;
    assign timeh_o     = timeh_q;

    // full 64-bit time moves by one per cycle once out of reset
    a_time_ticks: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> {timeh_o, time_o} == $past({timeh_o, time_o}) + 64'd1
    );

endmodule

`default_nettype wire

// File: hw/csr_read_port.sv
// CSR read port with write bypass
`default_nettype none

module csr_read_port #(
    parameter csr_pkg::csr_word_t hart_id_p   = '0,
    parameter csr_pkg::csr_word_t vendor_id_p = '0
) (
    input  wire                     we_i,
    input  wire csr_pkg::csr_addr_t waddr_i,
    input  wire csr_pkg::csr_addr_t raddr_i,
    input  wire csr_pkg::csr_word_t wdata_i,
    input  wire csr_pkg::csr_word_u mstatus_i,
    input  wire csr_pkg::csr_word_t mtvec_i,
    input  wire csr_pkg::csr_word_t mepc_i,
    input  wire csr_pkg::csr_word_t mcause_i,
    input  wire csr_pkg::csr_word_t mie_i,
    input  wire csr_pkg::csr_word_t mip_i,
    input  wire csr_pkg::csr_word_t mtval_i,
    input  wire csr_pkg::csr_word_t mscratch_i,
    input  wire csr_pkg::csr_word_t mcounteren_i,
    input  wire csr_pkg::csr_word_t mcycle_i,
    input  wire csr_pkg::csr_word_t mcycleh_i,
    input  wire csr_pkg::csr_word_t minstret_i,
    input  wire csr_pkg::csr_word_t minstreth_i,
    input  wire csr_pkg::csr_word_t time_i,
    input  wire csr_pkg::csr_word_t timeh_i,
    output csr_pkg::csr_word_t      rdata_o
);

    import csr_pkg::*;

    always_comb begin
        // own write wins, implemented or not
        if (we_i && (waddr_i == raddr_i)) begin
            rdata_o = wdata_i;
        end else begin
            case (raddr_i)
                csr_mstatus_a:    rdata_o = mstatus_i.raw;
                csr_misa_a:       rdata_o = misa_value;
                csr_mie_a:        rdata_o = mie_i;
                csr_mtvec_a:      rdata_o = mtvec_i;
                csr_mcounteren_a: rdata_o = mcounteren_i;
                csr_mscratch_a:   rdata_o = mscratch_i;
                csr_mepc_a:       rdata_o = mepc_i;
                csr_mcause_a:     rdata_o = mcause_i;
                csr_mtval_a:      rdata_o = mtval_i;
                csr_mip_a:        rdata_o = mip_i;
                csr_mcycle_a:     rdata_o = mcycle_i;
                csr_mcycleh_a:    rdata_o = mcycleh_i;
                csr_minstret_a:   rdata_o = minstret_i;
                csr_minstreth_a:  rdata_o = minstreth_i;
                csr_time_a:       rdata_o = time_i;
                csr_timeh_a:      rdata_o = timeh_i;
                csr_mvendorid_a:  rdata_o = vendor_id_p;
                csr_marchid_a:    rdata_o = '0;  // no architecture id assigned
                csr_mimpid_a:     rdata_o = '0;
                csr_mhartid_a:    rdata_o = hart_id_p;
                default:          rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/csr_unit.sv
// Machine-mode CSR unit
`default_nettype none

module csr_unit #(
    parameter csr_pkg::csr_word_t hart_id_p   = '0,
    parameter csr_pkg::csr_word_t vendor_id_p = '0
) (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     inst_valid_i,   // one retired instruction
    // execute stage port
    input  wire                     ex_we_i,
    input  wire csr_pkg::csr_addr_t ex_raddr_i,
    input  wire csr_pkg::csr_addr_t ex_waddr_i,
    input  wire csr_pkg::csr_word_t ex_wdata_i,
    // interrupt controller port
    input  wire                     clint_we_i,
    input  wire csr_pkg::csr_addr_t clint_raddr_i,
    input  wire csr_pkg::csr_addr_t clint_waddr_i,
    input  wire csr_pkg::csr_word_t clint_wdata_i,
    output csr_pkg::csr_word_t      ex_rdata_o,
    output csr_pkg::csr_word_t      clint_rdata_o,
    output logic                    global_int_en_o,
    output csr_pkg::csr_word_t      mtvec_o,
    output csr_pkg::csr_word_t      mepc_o,
    output csr_pkg::csr_word_t      mstatus_o
);

    import csr_pkg::*;

    csr_vec_t  wr_en;
    csr_vec_t  wr_from_ex;
    csr_word_u mstatus;
    csr_word_t mtvec;
    csr_word_t mepc;
    csr_word_t mcause;
    csr_word_t mie;
    csr_word_t mip;
    csr_word_t mtval;
    csr_word_t mscratch;
    csr_word_t mcounteren;
    csr_word_t mcycle;
    csr_word_t mcycleh;
    csr_word_t minstret;
    csr_word_t minstreth;
    csr_word_t time_val;
    csr_word_t timeh_val;

    csr_port_ctrl u_port_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ex_we_i      (ex_we_i),
        .clint_we_i   (clint_we_i),
        .ex_waddr_i   (ex_waddr_i),
        .clint_waddr_i(clint_waddr_i),
        .wr_en_o      (wr_en),
        .wr_from_ex_o (wr_from_ex)
    );

    csr_trap_regs u_trap_regs (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wr_en_i        (wr_en),
        .wr_from_ex_i   (wr_from_ex),
        .ex_wdata_i     (ex_wdata_i),
        .clint_wdata_i  (clint_wdata_i),
        .mstatus_o      (mstatus),
        .mtvec_o        (mtvec),
        .mepc_o         (mepc),
        .mcause_o       (mcause),
        .mie_o          (mie),
        .mip_o          (mip),
        .mtval_o        (mtval),
        .mscratch_o     (mscratch),
        .mcounteren_o   (mcounteren),
        .global_int_en_o(global_int_en_o)
    );

    csr_counters u_counters (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .wr_en_i      (wr_en),
        .wr_from_ex_i (wr_from_ex),
        .ex_wdata_i   (ex_wdata_i),
        .clint_wdata_i(clint_wdata_i),
        .mcycle_o     (mcycle),
        .mcycleh_o    (mcycleh),
        .minstret_o   (minstret),
        .minstreth_o  (minstreth),
        .time_o       (time_val),
        .timeh_o      (timeh_val)
    );

    csr_read_port #(
        .hart_id_p  (hart_id_p),
        .vendor_id_p(vendor_id_p)
    ) u_ex_read (
        .we_i        (ex_we_i),
        .waddr_i     (ex_waddr_i),
        .raddr_i     (ex_raddr_i),
        .wdata_i     (ex_wdata_i),
        .mstatus_i   (mstatus),
        .mtvec_i     (mtvec),
        .mepc_i      (mepc),
        .mcause_i    (mcause),
        .mie_i       (mie),
        .mip_i       (mip),
        .mtval_i     (mtval),
        .mscratch_i  (mscratch),
        .mcounteren_i(mcounteren),
        .mcycle_i    (mcycle),
        .mcycleh_i   (mcycleh),
        .minstret_i  (minstret),
        .minstreth_i (minstreth),
        .time_i      (time_val),
        .timeh_i     (timeh_val),
        .rdata_o     (ex_rdata_o)
    );

    csr_read_port #(
        .hart_id_p  (hart_id_p),
        .vendor_id_p(vendor_id_p)
    ) u_clint_read (
        .we_i        (clint_we_i),
        .waddr_i     (clint_waddr_i),
        .raddr_i     (clint_raddr_i),
        .wdata_i     (clint_wdata_i),
        .mstatus_i   (mstatus),
        .mtvec_i     (mtvec),
        .mepc_i      (mepc),
        .mcause_i    (mcause),
        .mie_i       (mie),
        .mip_i       (mip),
        .mtval_i     (mtval),
        .mscratch_i  (mscratch),
        .mcounteren_i(mcounteren),
        .mcycle_i    (mcycle),
        .mcycleh_i   (mcycleh),
        .minstret_i  (minstret),
        .minstreth_i (minstreth),
        .time_i      (time_val),
        .timeh_i     (timeh_val),
        .rdata_o     (clint_rdata_o)
    );

    // trap entry values for the interrupt controller
    assign mtvec_o   = mtvec;
    assign mepc_o    = mepc;
    assign mstatus_o = mstatus.raw;

endmodule

`default_nettype wire

// File: verif/tb_csr_unit.sv
// CSR unit directed testbench
`default_nettype none

module tb_csr_unit;

    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam csr_word_t seed        = 32'd92097;
    localparam int        est_cycles  = 400;             // estimate for all tests rounded up
    localparam int        timeout_cycles = 5 * est_cycles;
    localparam csr_word_t hart_id     = 32'd3;
    localparam csr_addr_t unknown_a   = 12'h7c0;
    localparam int        cycle_steps = 10;
    localparam int        time_steps  = 7;
    // mxl=1 in 31:30, I is bit 8, M is bit 12
    localparam csr_word_t misa_expected = (32'd1 << 30) | (32'd1 << 8) | (32'd1 << 12);

    logic      clk = 1'b0;
    logic      rst_n_i;
    logic      inst_valid_i;
    logic      ex_we_i;
    csr_addr_t ex_raddr_i;
    csr_addr_t ex_waddr_i;
    csr_word_t ex_wdata_i;
    logic      clint_we_i;
    csr_addr_t clint_raddr_i;
    csr_addr_t clint_waddr_i;
    csr_word_t clint_wdata_i;
    csr_word_t ex_rdata_o;
    csr_word_t clint_rdata_o;
    logic      global_int_en_o;
    csr_word_t mtvec_o;
    csr_word_t mepc_o;
    csr_word_t mstatus_o;

    int        errors = 0;
    int        checks = 0;
    int        tests_run = 0;
    int        err_at_start = 0;
    int        cycle_count = 0;
    string     test_name;
    csr_word_t rng_state = seed;
    csr_word_t shadow [csr_trap_num];   // expected trap register contents

    // same order as csr_idx_e so shadow and address share an index
    csr_addr_t trap_addrs [csr_trap_num] = '{
        csr_mstatus_a, csr_mie_a, csr_mtvec_a, csr_mcounteren_a, csr_mscratch_a,
        csr_mepc_a, csr_mcause_a, csr_mtval_a, csr_mip_a
    };

    csr_unit #(
        .hart_id_p  (hart_id),
        .vendor_id_p(32'h0)
    ) uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .ex_we_i        (ex_we_i),
        .ex_raddr_i     (ex_raddr_i),
        .ex_waddr_i     (ex_waddr_i),
        .ex_wdata_i     (ex_wdata_i),
        .clint_we_i     (clint_we_i),
        .clint_raddr_i  (clint_raddr_i),
        .clint_waddr_i  (clint_waddr_i),
        .clint_wdata_i  (clint_wdata_i),
        .ex_rdata_o     (ex_rdata_o),
        .clint_rdata_o  (clint_rdata_o),
        .global_int_en_o(global_int_en_o),
        .mtvec_o        (mtvec_o),
        .mepc_o         (mepc_o),
        .mstatus_o      (mstatus_o)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, tests did not finish", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic csr_word_t xorshift32(input csr_word_t x);
        csr_word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic csr_word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_word(input string label, input csr_word_t expected,
                              input csr_word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s/%s expected %h actual %h", test_name, label, expected, actual);
        end
    endtask

    task automatic check_bit(input string label, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s/%s expected %b actual %b", test_name, label, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s finished with %0d errors", test_name, errors - err_at_start);
    endtask

    // one cycle of port activity with outputs sampled at the falling edge
    task automatic write_cycle(input logic ex_we, input csr_addr_t ex_wa, input csr_word_t ex_wd,
                               input logic cl_we, input csr_addr_t cl_wa, input csr_word_t cl_wd,
                               input csr_addr_t ex_ra, input csr_addr_t cl_ra);
        @(posedge clk);
        ex_we_i       <= ex_we;
        ex_waddr_i    <= ex_wa;
        ex_wdata_i    <= ex_wd;
        clint_we_i    <= cl_we;
        clint_waddr_i <= cl_wa;
        clint_wdata_i <= cl_wd;
        ex_raddr_i    <= ex_ra;
        clint_raddr_i <= cl_ra;
        @(negedge clk);
    endtask

    task automatic idle_read(input csr_addr_t ex_ra, input csr_addr_t cl_ra);
        write_cycle(1'b0, '0, '0, 1'b0, '0, '0, ex_ra, cl_ra);
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        for (int i = 0; i < csr_trap_num; i++) begin
            idle_read(trap_addrs[i], trap_addrs[i]);
            check_word("ex trap read", '0, ex_rdata_o);
            check_word("clint trap read", '0, clint_rdata_o);
        end
        check_bit("int enable", 1'b0, global_int_en_o);
        check_word("mtvec out", '0, mtvec_o);
        check_word("mepc out", '0, mepc_o);
        check_word("mstatus out", '0, mstatus_o);
        idle_read(csr_misa_a, csr_mhartid_a);
        check_word("misa", misa_expected, ex_rdata_o);
        check_word("mhartid", hart_id, clint_rdata_o);
        idle_read(unknown_a, unknown_a);
        check_word("unknown addr", '0, ex_rdata_o);
        end_test();
    endtask

    task automatic test_port_writes();
        csr_word_t data;
        start_test("port_writes");
        for (int p = 0; p < 2; p++) begin   // p 0 writes from ex, 1 from clint
            for (int i = 0; i < csr_trap_num; i++) begin
                data = rand_word();
                write_cycle(p == 0, trap_addrs[i], data, p == 1, trap_addrs[i], data,
                            trap_addrs[i], trap_addrs[i]);
                check_word("own bypass", data, (p == 0) ? ex_rdata_o : clint_rdata_o);
                check_word("other old", shadow[i], (p == 0) ? clint_rdata_o : ex_rdata_o);
                shadow[i] = data;
                idle_read(trap_addrs[i], trap_addrs[i]);
                check_word("ex readback", data, ex_rdata_o);
                check_word("clint readback", data, clint_rdata_o);
            end
        end
        // read-only and unimplemented targets keep their values
        write_cycle(1'b1, csr_misa_a, rand_word(), 1'b1, csr_mhartid_a, rand_word(),
                    csr_mstatus_a, csr_mstatus_a);
        idle_read(csr_misa_a, csr_mhartid_a);
        check_word("misa after write", misa_expected, ex_rdata_o);
        check_word("mhartid after write", hart_id, clint_rdata_o);
        write_cycle(1'b1, unknown_a, rand_word(), 1'b0, '0, '0, csr_mstatus_a, csr_mstatus_a);
        idle_read(unknown_a, unknown_a);
        check_word("unknown after write", '0, clint_rdata_o);
        end_test();
    endtask

    task automatic test_collisions();
        csr_word_t da;
        csr_word_t db;
        start_test("collisions");
        da = rand_word();
        db = rand_word();
        write_cycle(1'b1, csr_mscratch_a, da, 1'b1, csr_mscratch_a, db,
                    csr_mscratch_a, csr_mscratch_a);
        check_word("ex bypass same", da, ex_rdata_o);
        check_word("clint bypass same", db, clint_rdata_o);
        shadow[idx_mscratch] = da;   // ex has priority
        idle_read(csr_mscratch_a, csr_mscratch_a);
        check_word("same reg winner", da, clint_rdata_o);
        da = rand_word();
        db = rand_word();
        write_cycle(1'b1, csr_mepc_a, da, 1'b1, csr_mcause_a, db, csr_mepc_a, csr_mepc_a);
        check_word("ex own data", da, ex_rdata_o);
        check_word("clint old mepc", shadow[idx_mepc], clint_rdata_o);
        shadow[idx_mepc]   = da;
        shadow[idx_mcause] = db;
        idle_read(csr_mepc_a, csr_mcause_a);
        check_word("mepc stored", da, ex_rdata_o);
        check_word("mcause stored", db, clint_rdata_o);
        end_test();
    endtask

    task automatic test_exports();
        csr_word_t d1;
        csr_word_t d2;
        start_test("exports");
        d1 = rand_word() | 32'h8;   // MIE set
        write_cycle(1'b1, csr_mstatus_a, d1, 1'b0, '0, '0, csr_mstatus_a, csr_mstatus_a);
        check_bit("int enable before edge", shadow[idx_mstatus][3], global_int_en_o);
        shadow[idx_mstatus] = d1;
        idle_read(csr_mstatus_a, csr_mstatus_a);
        check_bit("int enable set", 1'b1, global_int_en_o);
        check_word("mstatus out", d1, mstatus_o);
        d2 = rand_word() & ~32'h8;
        write_cycle(1'b0, '0, '0, 1'b1, csr_mstatus_a, d2, csr_mstatus_a, csr_mstatus_a);
        check_bit("int enable held", 1'b1, global_int_en_o);
        shadow[idx_mstatus] = d2;
        idle_read(csr_mstatus_a, csr_mstatus_a);
        check_bit("int enable clear", 1'b0, global_int_en_o);
        check_word("mstatus out", d2, mstatus_o);
        d1 = rand_word();
        d2 = rand_word();
        write_cycle(1'b1, csr_mtvec_a, d1, 1'b1, csr_mepc_a, d2, csr_mtvec_a, csr_mepc_a);
        check_word("mtvec out before edge", shadow[idx_mtvec], mtvec_o);
        shadow[idx_mtvec] = d1;
        shadow[idx_mepc]  = d2;
        idle_read(csr_mtvec_a, csr_mepc_a);
        check_word("mtvec out", d1, mtvec_o);
        check_word("mepc out", d2, mepc_o);
        end_test();
    endtask

    task automatic test_counters();
        csr_word_t base;
        csr_word_t hi;
        csr_word_t t0;
        csr_word_t data;
        int        valid_count;
        start_test("counters");
        base = rand_word() & 32'h7fff_ffff;   // far from wrap
        write_cycle(1'b1, csr_mcycle_a, base, 1'b0, '0, '0, csr_mcycle_a, csr_mcycle_a);
        idle_read(csr_mcycle_a, csr_mcycle_a);
        check_word("mcycle written", base, clint_rdata_o);
        repeat (cycle_steps) @(posedge clk);
        @(negedge clk);
        check_word("mcycle counted", base + cycle_steps, ex_rdata_o);
        // low half at all ones carries into mcycleh
        hi = rand_word() & 32'h7fff_ffff;
        write_cycle(1'b1, csr_mcycle_a, '1, 1'b1, csr_mcycleh_a, hi, csr_mcycle_a, csr_mcycleh_a);
        idle_read(csr_mcycle_a, csr_mcycleh_a);
        check_word("mcycle all ones", 32'hffff_ffff, ex_rdata_o);
        check_word("mcycleh before carry", hi, clint_rdata_o);
        idle_read(csr_mcycle_a, csr_mcycleh_a);
        check_word("mcycle wrapped", '0, ex_rdata_o);
        check_word("mcycleh carried", hi + 32'd1, clint_rdata_o);
        idle_read(csr_minstret_a, csr_minstreth_a);
        t0 = ex_rdata_o;
        valid_count = 0;
        for (int i = 0; i < 24; i++) begin
            data = rand_word();
            @(posedge clk);
            inst_valid_i <= data[0];
            if (data[0]) begin
                valid_count++;
            end
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;
        @(negedge clk);
        check_word("minstret", t0 + csr_word_t'(valid_count), ex_rdata_o);
        idle_read(csr_time_a, csr_timeh_a);
        t0 = ex_rdata_o;
        repeat (time_steps) @(posedge clk);
        @(negedge clk);
        check_word("time delta", time_steps, ex_rdata_o - t0);
        end_test();
    endtask

    initial begin
        rst_n_i       <= 1'b0;
        inst_valid_i  <= 1'b0;
        ex_we_i       <= 1'b0;
        ex_raddr_i    <= '0;
        ex_waddr_i    <= '0;
        ex_wdata_i    <= '0;
        clint_we_i    <= 1'b0;
        clint_raddr_i <= '0;
        clint_waddr_i <= '0;
        clint_wdata_i <= '0;
        for (int i = 0; i < csr_trap_num; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        test_reset_state();
        test_port_writes();
        test_collisions();
        test_exports();
        test_counters();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_unit.f
hw/csr_pkg.sv
hw/csr_port_ctrl.sv
hw/csr_trap_regs.sv
hw/csr_counters.sv
hw/csr_read_port.sv
hw/csr_unit.sv
verif/tb_csr_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_csr_unit -f csr_unit.f \
        --Mdir obj_dir -o sim_csr_unit \
    && ./obj_dir/sim_csr_unit > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
echo "simulation clean"
exit 0
